// File: include/ls_defs.svh
// Shared width, depth and timing macros, included by the load/store RTL and its testbench
`ifndef LS_DEFS_SVH
`define LS_DEFS_SVH

// ==============================
// Bus widths
// ==============================

// Data word, one 16-bit bus beat
`define LS_DATA_W 16

// Word address, physical address bits 19 down to 1
`define LS_WADDR_W 19

// ==============================
// Targets
// ==============================

// RAM decodes this many word address bits and aliases above them
`define LS_RAM_DEPTH_LOG2 10
// Cycles from a new RAM access to its ack
`define LS_RAM_WAIT 2
// Port register index width
`define LS_PORT_CNT_LOG2 4

`endif

// File: rtl/ls_pkg.sv
// Struct types shared by the load/store RTL and testbench, referenced as ls_pkg::name
`include "ls_defs.svh"

package ls_pkg;

  // ==============================
  // Command and response channels
  // ==============================

  // One load or store command from the microcode side
  typedef struct packed {
    logic                  write;    // Store when set, load otherwise
    logic                  io;       // Port space, offset used as address
    logic                  is_8bit;  // Byte access
    logic [15:0]           segment;
    logic [15:0]           offset;
    logic [`LS_DATA_W-1:0] wdata;    // Store data, low byte for byte stores
  } ls_cmd_t;

  // One completion, data register value plus command type echo
  typedef struct packed {
    logic [`LS_DATA_W-1:0] rdata;
    logic                  write;
  } ls_resp_t;

  // ==============================
  // Word bus
  // ==============================

  // Request held by the sequencer for the whole access
  typedef struct packed {
    logic [`LS_WADDR_W-1:0] addr;     // Word address
    logic [`LS_DATA_W-1:0]  wdata;
    logic [1:0]             bytesel;  // Bit 0 is the low lane
    logic                   wr_en;
    logic                   io;       // Selects the port bank
  } bus_req_t;

endpackage

// File: rtl/seg_addr_unit.sv
// Address former: registers the word address and alignment of each accepted command
`timescale 1ns/1ps
`include "ls_defs.svh"

module seg_addr_unit (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   load,
  input  ls_pkg::ls_cmd_t        cmd,
  output logic [`LS_WADDR_W-1:0] word_addr,
  output logic                   unaligned
);

  // Segment times 16 plus offset, shifted right by one
  // Segment part is always even, so only offset bit 0 is lost
  logic [`LS_WADDR_W-1:0] phys_word;

  assign phys_word = {cmd.segment, 3'b000} + {4'b0000, cmd.offset[15:1]};

  // Captured at acceptance, keeps the add off the bus path
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      word_addr <= '0;
      unaligned <= 1'b0;
    end else if (load) begin
      // Port space skips the segment add
      if (cmd.io) begin
        word_addr <= {{(`LS_WADDR_W - 16){1'b0}}, cmd.offset};
      end else begin
        word_addr <= phys_word;  // wraps at 1 MB
      end
      // Sequencer ignores this for ports
      unaligned <= cmd.offset[0];
    end
  end

endmodule

// File: rtl/load_store_fsm.sv
// Load/store sequencer: takes a command, runs one or two bus phases, holds the response
`timescale 1ns/1ps
`include "ls_defs.svh"

module load_store_fsm (
  input  logic                   clk,
  input  logic                   reset,
  // Command channel
  input  logic                   cmd_valid,
  input  ls_pkg::ls_cmd_t        cmd,
  output logic                   cmd_ready,
  // Response channel
  output logic                   resp_valid,
  output ls_pkg::ls_resp_t       resp,
  input  logic                   resp_ready,
  // Address unit
  input  logic [`LS_WADDR_W-1:0] word_addr,
  input  logic                   unaligned,
  output logic                   addr_load,
  // Word bus
  output logic                   bus_access,
  output ls_pkg::bus_req_t       bus_req,
  input  logic                   bus_ack,
  input  logic [`LS_DATA_W-1:0]  bus_rdata
);

  // ==============================
  // State and command registers
  // ==============================

  typedef enum logic [2:0] {
    S_IDLE,
    S_ISSUE,    // First access cycle of phase one
    S_WAIT1,    // Phase one waits for ack
    S_GAP,      // Access low between split phases
    S_ISSUE2,   // First access cycle of phase two
    S_WAIT2,    // Phase two waits for ack
    S_RESP      // Response held until accepted
  } state_t;

  state_t state;

  // Latched command type
  logic op_write;
  logic op_io;
  logic op_8bit;

  // Data register, store data or assembled load data
  logic [`LS_DATA_W-1:0] data_reg;

  logic accept;
  logic split;      // Unaligned word, two byte phases
  logic high_lane;  // Unaligned byte, high lane only
  logic phase2;

  // ==============================
  // Handshakes and decode
  // ==============================

  assign cmd_ready  = (state == S_IDLE);
  assign accept     = cmd_valid & cmd_ready;
  assign addr_load  = accept;

  // Ports are never split and always use the low lanes
  assign split      = ~op_io & unaligned & ~op_8bit;
  assign high_lane  = ~op_io & unaligned & op_8bit;

  assign phase2     = (state == S_ISSUE2) || (state == S_WAIT2);
  assign bus_access = (state == S_ISSUE) || (state == S_WAIT1) || phase2;

  assign resp_valid = (state == S_RESP);
  assign resp.rdata = data_reg;
  assign resp.write = op_write;

  // ==============================
  // Bus request
  // ==============================

  // All fields zero whenever no access is running
  always_comb begin
    bus_req = '0;
    if (bus_access) begin
      bus_req.io    = op_io;
      bus_req.wr_en = op_write;
      if (phase2) begin
        // High byte of the word goes to the low lane of the next word
        bus_req.addr    = word_addr + 1'b1;
        bus_req.bytesel = 2'b01;
        if (op_write) begin
          bus_req.wdata = {8'h00, data_reg[15:8]};
        end
      end else if (split || high_lane) begin
        // Low byte rides the high lane of the first word
        bus_req.addr    = word_addr;
        bus_req.bytesel = 2'b10;
        if (op_write) begin
          bus_req.wdata = {data_reg[7:0], 8'h00};
        end
      end else begin
        bus_req.addr    = word_addr;
        bus_req.bytesel = op_8bit ? 2'b01 : 2'b11;
        if (op_write) begin
          bus_req.wdata = op_8bit ? {8'h00, data_reg[7:0]} : data_reg;
        end
      end
    end
  end

  // ==============================
  // Sequencer
  // ==============================

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state    <= S_IDLE;
      op_write <= 1'b0;
      op_io    <= 1'b0;
      op_8bit  <= 1'b0;
    end else begin
      case (state)
        S_IDLE: begin
          if (accept) begin
            op_write <= cmd.write;
            op_io    <= cmd.io;
            op_8bit  <= cmd.is_8bit;
            state    <= S_ISSUE;
          end
        end
        // Targets never ack in the first access cycle
        S_ISSUE:  state <= S_WAIT1;
        S_WAIT1: begin
          if (bus_ack) begin
            state <= split ? S_GAP : S_RESP;
          end
        end
        S_GAP:    state <= S_ISSUE2;
        S_ISSUE2: state <= S_WAIT2;
        S_WAIT2: begin
          if (bus_ack) begin
            state <= S_RESP;
          end
        end
        S_RESP: begin
          if (resp_ready) begin
            state <= S_IDLE;
          end
        end
        default:  state <= S_IDLE;
      endcase
    end
  end

  // Data register, loaded with store data at acceptance
  // Loads assemble bytes from each ack and zero-extend byte results
  always_ff @(posedge clk) begin
    if (accept) begin
      data_reg <= cmd.wdata;
    end else if (bus_ack && !op_write) begin
      if (state == S_WAIT1) begin
        if (split) begin
          data_reg[7:0] <= bus_rdata[15:8];  // high byte follows in phase two
        end else if (high_lane) begin
          data_reg <= {8'h00, bus_rdata[15:8]};
        end else if (op_8bit) begin
          data_reg <= {8'h00, bus_rdata[7:0]};
        end else begin
          data_reg <= bus_rdata;
        end
      end else if (state == S_WAIT2) begin
        data_reg[15:8] <= bus_rdata[7:0];
      end
    end
  end

endmodule

// File: rtl/bus_router.sv
// Bus router: steers each word bus access to the RAM or the port bank by its io flag
`timescale 1ns/1ps
`include "ls_defs.svh"

module bus_router (
  // Sequencer side
  input  logic                  bus_access,
  input  ls_pkg::bus_req_t      bus_req,
  output logic                  bus_ack,
  output logic [`LS_DATA_W-1:0] bus_rdata,
  // Target strobes
  output logic                  ram_access,
  output logic                  port_access,
  // Target returns
  input  logic                  ram_ack,
  input  logic [`LS_DATA_W-1:0] ram_rdata,
  input  logic                  port_ack,
  input  logic [`LS_DATA_W-1:0] port_rdata
);

  // ==============================
  // Request decode
  // ==============================

  // Exactly one target sees the access
  // Request fields go to both targets unchanged
  assign ram_access  = bus_access & ~bus_req.io;
  assign port_access = bus_access & bus_req.io;

  // ==============================
  // Return path
  // ==============================

  // io is held stable until the ack, so the select cannot glitch mid-access
  // Idle bus selects the RAM side, which is quiet then
  always_comb begin
    if (bus_req.io) begin
      bus_ack   = port_ack;
      bus_rdata = port_rdata;
    end else begin
      bus_ack   = ram_ack;
      bus_rdata = ram_rdata;
    end
  end

endmodule

// File: rtl/word_ram.sv
// Word RAM target: byte-lane memory that acks a fixed number of cycles after each access
`timescale 1ns/1ps
`include "ls_defs.svh"

module word_ram (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  access,
  input  ls_pkg::bus_req_t      req,
  output logic                  ack,
  output logic [`LS_DATA_W-1:0] rdata
);

  localparam int DEPTH = 2 ** `LS_RAM_DEPTH_LOG2;
  localparam int CNT_W = $clog2(`LS_RAM_WAIT + 1);
  localparam logic [CNT_W-1:0] WAIT_CNT = `LS_RAM_WAIT;

  logic [`LS_DATA_W-1:0] mem [DEPTH];
  logic [`LS_RAM_DEPTH_LOG2-1:0] idx;
  logic access_d;   // access one cycle back, for rise detect
  logic rise;
  logic [CNT_W-1:0] cnt;
  logic [CNT_W-1:0] cnt_next;

  // Upper word address bits alias
  assign idx  = req.addr[`LS_RAM_DEPTH_LOG2-1:0];
  assign rise = access & ~access_d;

  // Counts cycles since the rise, zero when idle
  always_comb begin
    if (rise) begin
      cnt_next = 1'b1;
    end else if ((cnt != '0) && (cnt < WAIT_CNT)) begin
      cnt_next = cnt + 1'b1;
    end else begin
      cnt_next = '0;
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      access_d <= 1'b0;
      cnt      <= '0;
      ack      <= 1'b0;
    end else begin
      access_d <= access;
      cnt      <= cnt_next;
      ack      <= (cnt_next == WAIT_CNT);  // one-cycle pulse
    end
  end

  // Read data appears together with the ack
  always_ff @(posedge clk) begin
    if (cnt_next == WAIT_CNT) begin
      rdata <= mem[idx];
    end
  end

  // Per-lane write at the end of the ack cycle
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      for (int i = 0; i < DEPTH; i++) begin
        mem[i] <= '0;
      end
    end else if (ack && access && req.wr_en) begin
      if (req.bytesel[0]) mem[idx][7:0]  <= req.wdata[7:0];
      if (req.bytesel[1]) mem[idx][15:8] <= req.wdata[15:8];
    end
  end

endmodule

// File: rtl/io_port_bank.sv
// Port bank target: sixteen 16-bit port registers that ack one cycle after each access
`timescale 1ns/1ps
`include "ls_defs.svh"

module io_port_bank (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  access,
  input  ls_pkg::bus_req_t      req,
  output logic                  ack,
  output logic [`LS_DATA_W-1:0] rdata
);

  localparam int PORTS = 2 ** `LS_PORT_CNT_LOG2;

  logic [`LS_DATA_W-1:0] ports [PORTS];
  logic [`LS_PORT_CNT_LOG2-1:0] idx;
  logic access_d;
  logic rise;

  // Low address bits pick the port
  assign idx  = req.addr[`LS_PORT_CNT_LOG2-1:0];
  assign rise = access & ~access_d;

  // Ack and read data follow the rise by one cycle
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      access_d <= 1'b0;
      ack      <= 1'b0;
    end else begin
      access_d <= access;
      ack      <= rise;
    end
  end

  // Full word read, the sequencer trims bytes
  always_ff @(posedge clk) begin
    if (rise) rdata <= ports[idx];
  end

  // Per-lane write on the ack cycle
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      for (int i = 0; i < PORTS; i++) ports[i] <= '0;
    end else if (ack && access && req.wr_en) begin
      if (req.bytesel[0]) ports[idx][7:0]  <= req.wdata[7:0];
      if (req.bytesel[1]) ports[idx][15:8] <= req.wdata[15:8];
    end
  end

endmodule

// File: rtl/ls_top.sv
// Load/store subsystem top: address unit, sequencer, bus router, RAM and port bank
`timescale 1ns/1ps
`include "ls_defs.svh"

module ls_top (
  input  logic             clk,
  input  logic             reset,
  input  logic             cmd_valid,
  input  ls_pkg::ls_cmd_t  cmd,
  output logic             cmd_ready,
  output logic             resp_valid,
  output ls_pkg::ls_resp_t resp,
  input  logic             resp_ready
);

  // Address unit to sequencer
  logic [`LS_WADDR_W-1:0] word_addr;
  logic unaligned, addr_load;
  // Sequencer bus
  logic bus_access, bus_ack;
  ls_pkg::bus_req_t bus_req;
  logic [`LS_DATA_W-1:0] bus_rdata;
  // Target side
  logic ram_access, ram_ack, port_access, port_ack;
  logic [`LS_DATA_W-1:0] ram_rdata, port_rdata;

  seg_addr_unit seg_addr_unit_i (.clk, .reset, .load(addr_load), .cmd, .word_addr, .unaligned);

  load_store_fsm load_store_fsm_i (
    .clk, .reset, .cmd_valid, .cmd, .cmd_ready, .resp_valid, .resp, .resp_ready,
    .word_addr, .unaligned, .addr_load, .bus_access, .bus_req, .bus_ack, .bus_rdata
  );

  bus_router bus_router_i (
    .bus_access, .bus_req, .bus_ack, .bus_rdata, .ram_access, .port_access,
    .ram_ack, .ram_rdata, .port_ack, .port_rdata
  );

  // Both targets see the same request fields
  word_ram word_ram_i (.clk, .reset, .access(ram_access), .req(bus_req),
                       .ack(ram_ack), .rdata(ram_rdata));
  io_port_bank io_port_bank_i (.clk, .reset, .access(port_access), .req(bus_req),
                               .ack(port_ack), .rdata(port_rdata));

endmodule

// File: test/ls_checker.sv
// Handshake and bus protocol assertions, bound into every load_store_fsm instance
`timescale 1ns/1ps

module ls_checker (
  input  logic             clk,
  input  logic             reset,
  input  logic             cmd_ready,
  input  logic             resp_valid,
  input  logic             resp_ready,
  input  ls_pkg::ls_resp_t resp,
  input  logic             bus_access,
  input  logic             bus_ack,
  input  ls_pkg::bus_req_t bus_req
);

  // ==============================
  // Word bus
  // ==============================

  // Request held until the target acks
  a_req_stable: assert property (@(posedge clk) disable iff (reset)
    bus_access && !bus_ack |=> $stable(bus_req))
    else $error("bus request changed before the ack");

  // Some lane is always selected during an access
  a_lanes_set: assert property (@(posedge clk) disable iff (reset)
    bus_access |-> (bus_req.bytesel != 2'b00))
    else $error("bus access with no byte lane selected");

  // No new command while the bus is busy
  a_busy_not_ready: assert property (@(posedge clk) disable iff (reset)
    bus_access |-> !cmd_ready)
    else $error("command channel ready during a bus access");

  // ==============================
  // Response channel
  // ==============================

  // Stalled response keeps its value and stays valid
  a_resp_stable: assert property (@(posedge clk) disable iff (reset)
    resp_valid && !resp_ready |=> resp_valid && $stable(resp))
    else $error("response dropped or changed while stalled");

endmodule

bind load_store_fsm ls_checker ls_checker_i (
  .clk        (clk),
  .reset      (reset),
  .cmd_ready  (cmd_ready),
  .resp_valid (resp_valid),
  .resp_ready (resp_ready),
  .resp       (resp),
  .bus_access (bus_access),
  .bus_ack    (bus_ack),
  .bus_req    (bus_req)
);

// File: test/ls_tb.sv
// Table-driven testbench for ls_top, run as simulation top together with the bound checker
`timescale 1ns/1ps
`include "ls_defs.svh"

module ls_tb;

  localparam int N_TESTS         = 30;
  localparam int RESET_CYCLES    = 3;
  localparam int WATCHDOG_CYCLES = RESET_CYCLES + 40 * N_TESTS;
  localparam int RAM_BYTES       = 2 ** (`LS_RAM_DEPTH_LOG2 + 1);
  localparam int PORTS           = 2 ** `LS_PORT_CNT_LOG2;

  // One table row, expected value filled in by the reference model
  typedef struct {
    string            name;
    ls_pkg::ls_cmd_t  cmd;
    ls_pkg::ls_resp_t exp;
  } entry_t;

  logic             clk;
  logic             reset;
  logic             cmd_valid;
  logic             cmd_ready;
  logic             resp_valid;
  logic             resp_ready;
  ls_pkg::ls_cmd_t  cmd;
  ls_pkg::ls_resp_t resp;

  entry_t tbl [N_TESTS];
  int     n_tbl;
  int     errors;
  int     tests_failed;
  int     err_before;
  int     n_cmd;
  int     n_resp;
  string  cur_name;

  // Reference model state, byte addressed RAM aliased like the target
  logic [7:0]            ram_bytes [RAM_BYTES];
  logic [`LS_DATA_W-1:0] port_regs [PORTS];

  ls_top ls_top_i (.clk, .reset, .cmd_valid, .cmd, .cmd_ready, .resp_valid, .resp, .resp_ready);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // ==============================
  // Reference model
  // ==============================

  // Physical address is segment * 16 + offset mod 1 MB, ports use the offset index
  function automatic ls_pkg::ls_resp_t model_access(ls_pkg::ls_cmd_t c);
    logic [19:0]                   pa;
    logic [`LS_RAM_DEPTH_LOG2:0]   b0;
    logic [`LS_RAM_DEPTH_LOG2:0]   b1;
    logic [`LS_PORT_CNT_LOG2-1:0]  pi;
    ls_pkg::ls_resp_t              r;
    r.write = c.write;
    r.rdata = c.wdata;
    if (c.io) begin
      pi = c.offset[`LS_PORT_CNT_LOG2-1:0];
      if (c.write && c.is_8bit) port_regs[pi][7:0] = c.wdata[7:0];
      else if (c.write) port_regs[pi] = c.wdata;
      else if (c.is_8bit) r.rdata = {8'h00, port_regs[pi][7:0]};
      else r.rdata = port_regs[pi];
    end else begin
      pa = {c.segment, 4'h0} + {4'h0, c.offset};
      b0 = pa[`LS_RAM_DEPTH_LOG2:0];
      b1 = b0 + 1'b1;
      if (c.write) begin
        ram_bytes[b0] = c.wdata[7:0];
        if (!c.is_8bit) ram_bytes[b1] = c.wdata[15:8];
      end else if (c.is_8bit) begin
        r.rdata = {8'h00, ram_bytes[b0]};
      end else begin
        r.rdata = {ram_bytes[b1], ram_bytes[b0]};
      end
    end
    return r;
  endfunction

  task automatic add_entry(string name, bit wr, bit io, bit b8,
                           logic [15:0] seg, logic [15:0] off, logic [15:0] wd);
    ls_pkg::ls_cmd_t c;
    c = '{write: wr, io: io, is_8bit: b8, segment: seg, offset: off, wdata: wd};
    tbl[n_tbl].name = name;
    tbl[n_tbl].cmd  = c;
    tbl[n_tbl].exp  = model_access(c);
    n_tbl++;
  endtask

  // Columns: name, write, io, byte, segment, offset, write data
  task automatic build_table();
    add_entry("rd_unwritten_w",  0, 0, 0, 16'h0000, 16'h0100, 16'h0000);
    add_entry("rd_unwritten_b",  0, 0, 1, 16'h0123, 16'h0457, 16'h0000);
    add_entry("st_w_alias",      1, 0, 0, 16'h1000, 16'h0010, 16'hBEEF);
    add_entry("ld_w_alias",      0, 0, 0, 16'h1001, 16'h0000, 16'h0000);
    add_entry("ld_b_alias",      0, 0, 1, 16'h1001, 16'h0000, 16'h0000);
    add_entry("st_b_aligned",    1, 0, 1, 16'h2000, 16'h0004, 16'h12A5);
    add_entry("ld_b_aligned",    0, 0, 1, 16'h1FFF, 16'h0014, 16'h0000);
    add_entry("ld_w_after_b",    0, 0, 0, 16'h2000, 16'h0004, 16'h0000);
    add_entry("st_w_lo_nbr",     1, 0, 0, 16'h0000, 16'h0200, 16'h1111);
    add_entry("st_w_hi_nbr",     1, 0, 0, 16'h0000, 16'h0202, 16'h2222);
    add_entry("st_w_unaligned",  1, 0, 0, 16'h0000, 16'h0201, 16'h5A3C);
    add_entry("ld_w_unaligned",  0, 0, 0, 16'h0000, 16'h0201, 16'h0000);
    add_entry("ld_w_first_word", 0, 0, 0, 16'h0000, 16'h0200, 16'h0000);
    add_entry("ld_w_next_word",  0, 0, 0, 16'h0000, 16'h0202, 16'h0000);
    add_entry("st_w_base",       1, 0, 0, 16'h0000, 16'h0300, 16'h7788);
    add_entry("st_b_unaligned",  1, 0, 1, 16'h0000, 16'h0301, 16'h00C4);
    add_entry("ld_b_unaligned",  0, 0, 1, 16'h0000, 16'h0301, 16'h0000);
    add_entry("ld_w_base",       0, 0, 0, 16'h0000, 16'h0300, 16'h0000);
    add_entry("io_st_w_p3",      1, 1, 0, 16'h0000, 16'h0003, 16'hA1B2);
    add_entry("io_st_w_p15",     1, 1, 0, 16'h0000, 16'h000F, 16'h1234);
    add_entry("io_st_b_p7",      1, 1, 1, 16'h0000, 16'h0007, 16'h9956);
    add_entry("io_ld_w_p3",      0, 1, 0, 16'h0000, 16'h0003, 16'h0000);
    add_entry("io_ld_w_p15",     0, 1, 0, 16'h0000, 16'h000F, 16'h0000);
    add_entry("io_ld_w_p7",      0, 1, 0, 16'h0000, 16'h0007, 16'h0000);
    add_entry("io_ld_b_p3",      0, 1, 1, 16'h0000, 16'h0003, 16'h0000);
    add_entry("ram_ld_w_3",      0, 0, 0, 16'h0000, 16'h0006, 16'h0000);
    add_entry("ram_ld_w_15",     0, 0, 0, 16'h0000, 16'h001E, 16'h0000);
    add_entry("st_w_wrap",       1, 0, 0, 16'hFFFF, 16'h000F, 16'hCAFE);
    add_entry("ld_w_wrap",       0, 0, 0, 16'hFFFF, 16'h000F, 16'h0000);
    add_entry("ld_b_wrap_lo",    0, 0, 1, 16'h0000, 16'h0000, 16'h0000);
  endtask

  // ==============================
  // Checks and channel drivers
  // ==============================

  task automatic check_resp(string name, ls_pkg::ls_resp_t exp, ls_pkg::ls_resp_t act);
    if (act !== exp) begin
      $display("[ERROR] %s: expected rdata=%h write=%b, actual rdata=%h write=%b",
               name, exp.rdata, exp.write, act.rdata, act.write);
      errors++;
    end
  endtask

  task automatic check_ready(string name, logic exp, logic act);
    if (act !== exp) begin
      $display("[ERROR] %s: expected %b, actual %b", name, exp, act);
      errors++;
    end
  endtask

  // Hold the command until the DUT takes it
  task automatic send_cmd(ls_pkg::ls_cmd_t c);
    @(posedge clk);
    cmd_valid <= 1'b1;
    cmd       <= c;
    @(negedge clk);
    while (!cmd_ready) @(negedge clk);
    @(posedge clk);
    cmd_valid <= 1'b0;
    cmd       <= '0;
  endtask

  // Random stall of 0 to 3 cycles before accepting the response
  task automatic take_resp(string name, ls_pkg::ls_resp_t exp);
    int stall;
    stall = $urandom % 4;
    @(negedge clk);
    while (!resp_valid) @(negedge clk);
    repeat (stall) @(negedge clk);
    check_resp(name, exp, resp);
    @(posedge clk);
    resp_ready <= 1'b1;
    @(posedge clk);
    resp_ready <= 1'b0;
    @(negedge clk);
    // A second response here would mean a duplicate
    check_ready({name, "_resp_done"}, 1'b0, resp_valid);
  endtask

  task automatic report_test(string name, int err_start);
    if (errors == err_start) begin
      $display("PASS  %s", name);
    end else begin
      $display("FAIL  %s", name);
      tests_failed++;
    end
  endtask

  // Handshake counters, no command lost or taken twice
  always @(posedge clk) begin
    if (!reset) begin
      if (cmd_valid && cmd_ready) n_cmd++;
      if (resp_valid && resp_ready) n_resp++;
    end
  end

  // ==============================
  // Watchdog and main sequence
  // ==============================

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Timeout: test %s did not finish within %0d cycles", cur_name, WATCHDOG_CYCLES);
    $display("ERRORS FOUND");
    $finish;
  end

  initial begin
    reset        = 1'b1;
    cmd_valid    = 1'b0;
    cmd          = '0;
    resp_ready   = 1'b0;
    errors       = 0;
    tests_failed = 0;
    n_tbl        = 0;
    n_cmd        = 0;
    n_resp       = 0;
    cur_name     = "reset_state";
    void'($urandom(28));
    for (int i = 0; i < RAM_BYTES; i++) ram_bytes[i] = 8'h00;
    for (int i = 0; i < PORTS; i++) port_regs[i] = '0;
    build_table();

    repeat (RESET_CYCLES) @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);
    err_before = errors;
    check_ready("reset_cmd_ready", 1'b1, cmd_ready);
    check_ready("reset_resp_valid", 1'b0, resp_valid);
    report_test("reset_state", err_before);

    for (int i = 0; i < N_TESTS; i++) begin
      cur_name   = tbl[i].name;
      err_before = errors;
      send_cmd(tbl[i].cmd);
      take_resp(tbl[i].name, tbl[i].exp);
      report_test(tbl[i].name, err_before);
    end

    if (n_cmd != N_TESTS || n_resp != N_TESTS) begin
      $display("Handshake count mismatch: %0d commands and %0d responses for %0d tests",
               n_cmd, n_resp, N_TESTS);
      errors++;
    end
    $display("Tests run %0d, tests failed %0d, errors %0d", N_TESTS + 1, tests_failed, errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

// File: ls_subsys.f
+incdir+include
rtl/ls_pkg.sv
rtl/seg_addr_unit.sv
rtl/load_store_fsm.sv
rtl/bus_router.sv
rtl/word_ram.sv
rtl/io_port_bank.sv
rtl/ls_top.sv
test/ls_checker.sv
test/ls_tb.sv

// File: run_sim.sh
#!/bin/sh
# Builds the load/store testbench with Verilator, runs it, then scans the log
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal --top-module ls_tb \
  -f ls_subsys.f --Mdir obj_dir -o ls_sim \
  && ./obj_dir/ls_sim > sim.log 2>&1 \
  || echo "ERRORS FOUND" >> sim.log

cat sim.log

grep -q "ERRORS FOUND" sim.log \
  && { echo "Simulation FAILED"; exit 1; } \
  || { echo "Simulation PASSED"; exit 0; }
